/* Makefile */
SIM := obj_dir/Vtb_rv_core

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): rv_core.f rtl/rv_core_cfg.svh $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing -Wno-fatal -f rv_core.f --top-module tb_rv_core

run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "^Simulation PASSED$$" sim.log || (echo "Run failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* rtl/rv_core.sv */
`timescale 1ns/100ps

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::inst_t    instruction,
    output rv_core_pkg::addr_t    pc,
    input  rv_core_pkg::irq_vec_t interrupt_vector,
    output logic                  interrupt_pending,
    output logic                  interrupt_done,
    output rv_core_pkg::irq_vec_t mcause,
    output rv_core_pkg::xword_t   bus_address,
    output rv_core_pkg::xword_t   bus_write_data,
    output logic                  bus_write_enable,
    output logic                  heartbeat,
    input  rv_core_pkg::reg_idx_t dbg_idx,
    output rv_core_pkg::xword_t   dbg_data
);
    // Trap control to execute
    logic                  redirect;
    rv_core_pkg::addr_t    redirect_pc;
    logic                  kill;
    logic                  mret_seen;

    // Register file ports
    rv_core_pkg::reg_idx_t rs1_idx;
    rv_core_pkg::reg_idx_t rs2_idx;
    rv_core_pkg::xword_t   rs1_data;
    rv_core_pkg::xword_t   rs2_data;
    logic                  wr_en;
    rv_core_pkg::reg_idx_t wr_idx;
    rv_core_pkg::xword_t   wr_data;

    rv_trap_ctrl u_trap_ctrl (
        .clk               (clk),
        .reset             (reset),
        .interrupt_vector  (interrupt_vector),
        .pc                (pc),
        .mret_seen         (mret_seen),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .kill              (kill),
        .interrupt_pending (interrupt_pending),
        .interrupt_done    (interrupt_done),
        .mcause            (mcause)
    );

    rv_heartbeat u_heartbeat (
        .clk       (clk),
        .reset     (reset),
        .heartbeat (heartbeat)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data)
    );

    rv_execute u_execute (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .kill             (kill),
        .mret_seen        (mret_seen),
        .rs1_idx          (rs1_idx),
        .rs2_idx          (rs2_idx),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .wr_en            (wr_en),
        .wr_idx           (wr_idx),
        .wr_data          (wr_data),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable)
    );

endmodule

/* rtl/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Core configuration

// First fetch address out of reset
`define RV_RESET_PC 32'd44

// Interrupt service entry point
`define RV_TRAP_BASE 32'd0

// Clocks per heartbeat half period
`define RV_HEARTBEAT_DIV 12

// Integer register and bus data width
`define RV_XLEN 64

`endif

/* rtl/rv_core_pkg.sv */
`include "rv_core_cfg.svh"

package rv_core_pkg;

    // Register file entry, ALU result, bus data
    typedef logic [`RV_XLEN-1:0] xword_t;

    // Raw 32-bit instruction encoding
    typedef logic [31:0] inst_t;

    // Instruction fetch address, also mepc
    typedef logic [31:0] addr_t;

    // rs1 / rs2 / rd field
    typedef logic [4:0] reg_idx_t;

    // External interrupt lines
    typedef logic [3:0] irq_vec_t;

    // Trap controller states
    typedef enum logic [1:0] {
        RUN,      // Normal program flow, requests accepted
        ENTER,    // Bubble cycle right after the entry jump
        SERVICE   // ISR running, waiting for MRET
    } trap_state_t;

endpackage

/* rtl/rv_execute.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_execute (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::inst_t    instruction,
    output rv_core_pkg::addr_t    pc,
    input  logic                  redirect,
    input  rv_core_pkg::addr_t    redirect_pc,
    input  logic                  kill,
    output logic                  mret_seen,
    output rv_core_pkg::reg_idx_t rs1_idx,
    output rv_core_pkg::reg_idx_t rs2_idx,
    input  rv_core_pkg::xword_t   rs1_data,
    input  rv_core_pkg::xword_t   rs2_data,
    output logic                  wr_en,
    output rv_core_pkg::reg_idx_t wr_idx,
    output rv_core_pkg::xword_t   wr_data,
    output rv_core_pkg::xword_t   bus_address,
    output rv_core_pkg::xword_t   bus_write_data,
    output logic                  bus_write_enable
);
    localparam logic [6:0]         OP_LUI    = 7'b0110111;
    localparam logic [6:0]         OP_IMM    = 7'b0010011;
    localparam logic [6:0]         OP_REG    = 7'b0110011;
    localparam logic [6:0]         OP_STORE  = 7'b0100011;
    localparam rv_core_pkg::inst_t INST_MRET = 32'h3020_0073;
    localparam rv_core_pkg::inst_t INST_NOP  = 32'h0000_0013; // addi x0, x0, 0

    rv_core_pkg::inst_t  ir;
    logic                ir_valid;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    rv_core_pkg::xword_t imm_u;
    rv_core_pkg::xword_t imm_i;
    rv_core_pkg::xword_t imm_s;
    logic                is_lui;
    logic                is_addi;
    logic                is_add;
    logic                is_sd;
    logic                exec_ok;

    // Field split
    assign opcode  = ir[6:0];
    assign funct3  = ir[14:12];
    assign funct7  = ir[31:25];
    assign rs1_idx = ir[19:15];
    assign rs2_idx = ir[24:20];
    assign wr_idx  = ir[11:7];

    // Immediates, all sign-extended to XLEN
    assign imm_u = {{(`RV_XLEN-32){ir[31]}}, ir[31:12], 12'b0};
    assign imm_i = {{(`RV_XLEN-12){ir[31]}}, ir[31:20]};
    assign imm_s = {{(`RV_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]}; // Split store offset

    assign is_lui  = (opcode == OP_LUI);
    assign is_addi = (opcode == OP_IMM) && (funct3 == 3'b000);
    assign is_add  = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0);
    assign is_sd   = (opcode == OP_STORE) && (funct3 == 3'b011);

    // Entry redirect squashes the instruction in ir
    assign exec_ok   = ir_valid && !redirect;
    assign mret_seen = ir_valid && (ir == INST_MRET);

    assign wr_en = exec_ok && (is_lui || is_addi || is_add); // Unknown opcodes fall through

    always_comb begin
        wr_data = rs1_data + rs2_data; // ADD
        if (is_lui) begin
            wr_data = imm_u;
        end else if (is_addi) begin
            wr_data = rs1_data + imm_i;
        end
    end

    // Fetch: pc and ir
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc       <= `RV_RESET_PC;
            ir       <= INST_NOP;
            ir_valid <= 1'b0;
        end else begin
            pc       <= redirect ? redirect_pc : pc + 32'd4;
            ir       <= instruction;
            ir_valid <= !kill; // Bubble for the wrong-path fetch
        end
    end

    // Store strobe, one cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus_write_enable <= 1'b0;
        end else begin
            bus_write_enable <= exec_ok && is_sd;
        end
    end

    always_ff @(posedge clk) begin
        bus_address    <= rs1_data + imm_s; // Effective address
        bus_write_data <= rs2_data;
    end

endmodule

/* rtl/rv_heartbeat.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_heartbeat (
    input  logic clk,
    input  logic reset,
    output logic heartbeat
);
    // At least one bit even for a divider of 1
    localparam int CNT_W = ($clog2(`RV_HEARTBEAT_DIV) > 0) ? $clog2(`RV_HEARTBEAT_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RV_HEARTBEAT_DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cnt       <= '0;
            heartbeat <= 1'b0;
        end else if (cnt == CNT_LAST) begin
            cnt       <= '0;           // Wrap
            heartbeat <= ~heartbeat;   // One half period done
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::reg_idx_t rs1_idx,
    input  rv_core_pkg::reg_idx_t rs2_idx,
    output rv_core_pkg::xword_t   rs1_data,
    output rv_core_pkg::xword_t   rs2_data,
    input  logic                  wr_en,
    input  rv_core_pkg::reg_idx_t wr_idx,
    input  rv_core_pkg::xword_t   wr_data,
    input  rv_core_pkg::reg_idx_t dbg_idx,
    output rv_core_pkg::xword_t   dbg_data
);
    rv_core_pkg::xword_t regs [1:31]; // x0 has no storage

    // Hard-wired zero for x0
    function automatic rv_core_pkg::xword_t read_reg(input rv_core_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        return regs[idx];
    endfunction

    // Reads follow both the index and the register contents
    always_comb begin
        rs1_data = read_reg(rs1_idx);
        rs2_data = read_reg(rs2_idx);
        dbg_data = read_reg(dbg_idx); // Testbench peek port
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data; // Writes to x0 dropped
        end
    end

endmodule

/* rtl/rv_trap_ctrl.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_trap_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::irq_vec_t interrupt_vector,
    input  rv_core_pkg::addr_t    pc,
    input  logic                  mret_seen,
    output logic                  redirect,
    output rv_core_pkg::addr_t    redirect_pc,
    output logic                  kill,
    output logic                  interrupt_pending,
    output logic                  interrupt_done,
    output rv_core_pkg::irq_vec_t mcause
);
    rv_core_pkg::irq_vec_t    vec_1;       // First sync stage
    rv_core_pkg::irq_vec_t    vec_2;       // Second sync stage
    rv_core_pkg::trap_state_t state;
    rv_core_pkg::addr_t       mepc;
    logic                     armed;       // Vector seen low since last entry
    logic                     slot_empty;  // ir holds a bubble this cycle
    logic                     entry_req;
    logic                     ret_req;

    // Two consecutive nonzero samples needed
    assign entry_req = (state == rv_core_pkg::RUN) && armed &&
                       (vec_1 != '0) && (vec_2 != '0);
    assign ret_req   = mret_seen && (state == rv_core_pkg::SERVICE); // Stray MRET ignored

    assign redirect    = entry_req | ret_req;
    assign redirect_pc = entry_req ? `RV_TRAP_BASE : mepc;
    assign kill        = entry_req | ret_req; // Wrong-path fetch lands in ir at this edge

    assign interrupt_pending = (state != rv_core_pkg::RUN);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            vec_1          <= '0;
            vec_2          <= '0;
            state          <= rv_core_pkg::RUN;
            armed          <= 1'b1;
            slot_empty     <= 1'b1;  // First slot after reset holds the no-op
            interrupt_done <= 1'b0;
            mcause         <= '0;
            mepc           <= `RV_RESET_PC;
        end else begin
            vec_1          <= interrupt_vector;
            vec_2          <= vec_1;
            slot_empty     <= kill;
            interrupt_done <= ret_req; // One-cycle pulse after return
            if (entry_req) begin
                armed <= 1'b0;
            end else if (vec_2 == '0) begin
                armed <= 1'b1; // Re-arm once the line has dropped
            end
            case (state)
                rv_core_pkg::RUN: begin
                    if (entry_req) begin
                        state  <= rv_core_pkg::ENTER;
                        mcause <= vec_2;
                        // Suppressed instruction sits at pc - 4 unless ir is a bubble
                        mepc   <= slot_empty ? pc : pc - 32'd4;
                    end
                end
                rv_core_pkg::ENTER:   state <= rv_core_pkg::SERVICE; // Killed slot drains
                rv_core_pkg::SERVICE: if (ret_req) state <= rv_core_pkg::RUN;
                default:              state <= rv_core_pkg::RUN;
            endcase
        end
    end

endmodule

/* rv_core.f */
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_trap_ctrl.sv
rtl/rv_heartbeat.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_core.sv
sim/tb_rv_core.sv

/* sim/tb_rv_core.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module tb_rv_core;
    localparam int N_MAIN = 40;
    localparam int N_IRQ = 6;
    localparam int IRQ_OVERHEAD = 16;  // Sync, entry bubble, ISR, return bubble
    localparam int TIMEOUT_CYCLES = N_MAIN * IRQ_OVERHEAD + 200;
    localparam logic [63:0] END_ADDR = 64'hFFFF_FFFF_FFFF_F800;  // -2048 off x0
    localparam logic [63:0] ISR_ADDR = 64'hFFFF_FFFF_FFFF_F808;  // -2040 off x0
    localparam int K_LUI = 0, K_ADDI = 1, K_ADD = 2, K_SD = 3, K_MRET = 4;

    logic                  clk;
    logic                  reset;
    rv_core_pkg::inst_t    instruction;
    rv_core_pkg::addr_t    pc;
    rv_core_pkg::irq_vec_t interrupt_vector;
    logic                  interrupt_pending;
    logic                  interrupt_done;
    rv_core_pkg::irq_vec_t mcause;
    rv_core_pkg::xword_t   bus_address;
    rv_core_pkg::xword_t   bus_write_data;
    logic                  bus_write_enable;
    logic                  heartbeat;
    rv_core_pkg::reg_idx_t dbg_idx;
    rv_core_pkg::xword_t   dbg_data;

    rv_core_pkg::inst_t  imem [128];       // Word i sits at byte address 4*i
    rv_core_pkg::inst_t  end_word;
    rv_core_pkg::xword_t model_regs [32];  // Architectural state, no interrupts
    rv_core_pkg::xword_t exp_addr_q [$];
    rv_core_pkg::xword_t exp_data_q [$];
    logic [31:0] rng = 32'd39811;
    int test_errs [1:5] = '{default: 0};
    int checks = 0;
    int cycles = 0;
    int isr_writes = 0;
    int done_count = 0;
    int hb_cnt = 0;
    int hb_toggles = 0;
    logic end_seen = 1'b0;
    logic hb_run = 1'b0;
    logic hb_last = 1'b0;

    rv_core dut0 (.*);

    always #2 clk = ~clk;

    // Instruction port, answered in the same cycle
    assign instruction = (pc[31:9] == '0) ? imem[pc[8:2]] : end_word;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic rv_core_pkg::inst_t encode(input int kind, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [19:0] imm);
        case (kind)
            K_LUI:   return {imm, rd, 7'b0110111};
            K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_ADD:   return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SD:    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
            default: return 32'h3020_0073;  // MRET
        endcase
    endfunction

    task automatic check_value(input int test, input string name,
                               input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            test_errs[test]++;
        end
    endtask

    task automatic report_problem(input int test, input string what);
        $display("Error in test %0d: %s", test, what);
        test_errs[test]++;
    endtask

    task automatic print_test(input int test, input string what);
        $display("Test %0d %s: %0d error(s)", test, what, test_errs[test]);
    endtask

    // Random main program, run through the model as it is built
    task automatic build_program();
        int i;
        int kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [19:0] imm;
        logic [31:0] r;
        rv_core_pkg::xword_t ea;
        for (i = 0; i < 128; i++) begin
            imem[i] = end_word;  // Past the program everything is the end marker
        end
        imem[0] = encode(K_ADDI, 31, 31, 0, 20'd1);    // ISR bumps x31
        imem[1] = encode(K_SD, 0, 0, 31, 20'h808);     // and stores it
        imem[2] = encode(K_MRET, 0, 0, 0, 20'd0);
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (i = 0; i < N_MAIN; i++) begin
            kind = int'(next_rand() % 4);
            rd   = 5'(1 + next_rand() % 30);
            rs1  = 5'(1 + next_rand() % 30);
            rs2  = 5'(1 + next_rand() % 30);
            r    = next_rand();
            imm  = (kind == K_SD) ? {9'b0, r[10:3], 3'b0} : r[19:0];  // Stores stay low
            imem[`RV_RESET_PC / 4 + i] = encode(kind, rd, rs1, rs2, imm);
            ea = model_regs[rs1] + {{52{imm[11]}}, imm[11:0]};
            case (kind)
                K_LUI:  model_regs[rd] = {{32{imm[19]}}, imm, 12'b0};
                K_ADDI: model_regs[rd] = ea;
                K_ADD:  model_regs[rd] = model_regs[rs1] + model_regs[rs2];
                default: begin
                    if (ea != ISR_ADDR) begin
                        exp_addr_q.push_back(ea);
                        exp_data_q.push_back(model_regs[rs2]);
                    end
                end
            endcase
        end
    endtask

    // Hold each vector until the ISR has returned
    task automatic drive_interrupts();
        int k;
        int gap;
        rv_core_pkg::irq_vec_t vec;
        for (k = 0; k < N_IRQ; k++) begin
            gap = 2 + int'(next_rand() % 8);
            repeat (gap) @(posedge clk);
            vec = 4'(1 + next_rand() % 15);
            interrupt_vector <= vec;
            @(negedge clk);
            while (!interrupt_pending) @(negedge clk);
            check_value(4, "mcause", 64'(mcause), 64'(vec));
            while (!interrupt_done) @(negedge clk);
            @(posedge clk);
            interrupt_vector <= '0;
        end
    endtask

    // Bus and return monitor, mid-cycle
    always @(negedge clk) begin
        if (reset && bus_write_enable) begin
            if (bus_address == ISR_ADDR) begin
                check_value(4, "bus_write_data", bus_write_data, 64'(isr_writes + 1));
                isr_writes++;
            end else if (bus_address == END_ADDR) begin
                end_seen = 1'b1;
            end else if (exp_addr_q.size() == 0) begin
                report_problem(2, $sformatf("unexpected bus write to 0x%h", bus_address));
            end else begin
                check_value(2, "bus_address", bus_address, exp_addr_q.pop_front());
                check_value(2, "bus_write_data", bus_write_data, exp_data_q.pop_front());
            end
        end
        if (reset && interrupt_done) begin
            done_count++;
            check_value(4, "isr write count", 64'(isr_writes), 64'(done_count));
        end
    end

    // Heartbeat period, counted in core edges since reset release
    always @(negedge clk) begin
        if (hb_run) hb_cnt++;
        if (reset) hb_run = 1'b1;
        if (hb_run && (heartbeat != hb_last)) begin
            check_value(5, "heartbeat period", 64'(hb_cnt), 64'(`RV_HEARTBEAT_DIV));
            hb_cnt = 0;
            hb_last = heartbeat;
            hb_toggles++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int i;
        int failed;
        clk = 1'b0;
        reset = 1'b1;
        interrupt_vector = '0;
        dbg_idx = '0;
        end_word = encode(K_SD, 0, 0, 0, 20'h800);  // sd x0, -2048(x0)
        build_program();
        #1 reset = 1'b0;  // Async assert ahead of the first edge
        #0.5;
        check_value(1, "pc", 64'(pc), 64'(`RV_RESET_PC));
        check_value(1, "bus_write_enable", 64'(bus_write_enable), 64'd0);
        check_value(1, "interrupt_pending", 64'(interrupt_pending), 64'd0);
        check_value(1, "interrupt_done", 64'(interrupt_done), 64'd0);
        print_test(1, "reset values");
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        fork
            drive_interrupts();
            while (!end_seen) @(negedge clk);
        join
        if (exp_addr_q.size() != 0) begin
            report_problem(2, $sformatf("%0d store(s) never reached the bus", exp_addr_q.size()));
        end
        print_test(2, "main bus writes");
        for (i = 0; i < 32; i++) begin
            @(posedge clk);
            dbg_idx <= 5'(i);
            @(negedge clk);
            if (i == 31) begin
                check_value(4, "dbg_data x31", dbg_data, 64'(N_IRQ));  // ISR counter
            end else begin
                check_value(3, $sformatf("dbg_data x%0d", i), dbg_data, model_regs[i]);
            end
        end
        print_test(3, "final registers");
        check_value(4, "interrupt_done count", 64'(done_count), 64'(N_IRQ));
        print_test(4, "interrupts");
        if (hb_toggles == 0) begin
            report_problem(5, "heartbeat never toggled");
        end
        print_test(5, "heartbeat");
        failed = 0;
        for (i = 1; i <= 5; i++) begin
            failed += (test_errs[i] != 0) ? 1 : 0;
        end
        $display("Tests run 5, failed %0d, checks %0d", failed, checks);
        if (failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
